//--- sources.f
+incdir+tb
common/bp_pkg.sv
agree_predictor/agree_btb.sv
agree_predictor/agree_pht.sv
agree_predictor/agree_predictor.sv
design/ghr_index.sv
design/fetch_pc.sv
design/branch_unit_top.sv
tb/branch_unit_tb.sv

//--- run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    --top-module branch_unit_tb -f sources.f -o branch_unit_sim

./obj_dir/branch_unit_sim > sim.log 2>&1 || { cat sim.log; echo "Simulator exited with an error"; exit 1; }
cat sim.log

if grep -q "Errors found" sim.log; then
    echo "Simulation failed"
    exit 1
fi

echo "Simulation passed"

//--- tb/bp_model.svh
// Reference model of BTB, PHT, history and fetch PC, included inside the testbench module
`ifndef BP_MODEL_SVH
`define BP_MODEL_SVH

logic [31:0] m_pc;                              // Expected fetch PC
logic        m_valid  [BTB_DEPTH];
logic [31:0] m_tag    [BTB_DEPTH];              // PC bits above the index
logic [31:0] m_target [BTB_DEPTH];
logic        m_bias   [BTB_DEPTH];
int          m_cnt    [PHT_DEPTH];              // Agree counters, 0 to 3
int          m_ghr;                             // Newest outcome in bit 0

logic        e_hit;
logic        e_bias_valid;                      // Entry written, so bias is defined
logic        e_bias;
logic        e_pred;
logic        e_flush;
int          e_idx;
logic [31:0] e_next_pc;

task automatic model_reset();
    m_pc  = RESET_PC;
    m_ghr = 0;
    for (int i = 0; i < BTB_DEPTH; i++) begin
        m_valid[i]  = 1'b0;
        m_tag[i]    = '0;
        m_target[i] = '0;
        m_bias[i]   = 1'b0;
    end
    for (int i = 0; i < PHT_DEPTH; i++) begin
        m_cnt[i] = 2;                           // Weakly agree
    end
endtask

function automatic int btb_slot(input logic [31:0] pc);
    return int'((pc >> 2) % BTB_DEPTH);         // Word address modulo table size
endfunction

// Expected outputs for the current model state and driven commit inputs
task automatic model_predict();
    int b;
    b            = btb_slot(m_pc);
    e_idx        = int'((m_pc >> 2) % PHT_DEPTH) ^ m_ghr;
    e_hit        = m_valid[b] && (m_tag[b] == (m_pc >> (BTB_IW + 2)));
    e_bias_valid = m_valid[b];
    e_bias       = m_bias[b];
    e_pred       = e_hit && ((m_cnt[e_idx] >= 2) == e_bias);    // Agree keeps the bias
    e_flush      = commit_is_br_i && (commit_pred_i != commit_taken_i);
    if (e_flush) begin
        e_next_pc = commit_taken_i ? commit_target_i : commit_pc_i + 32'd4;
    end else if (!fetch_en_i) begin
        e_next_pc = m_pc;                       // Stalled
    end else if (e_pred) begin
        e_next_pc = m_target[b];
    end else begin
        e_next_pc = m_pc + 32'd4;
    end
endtask

// State change at the coming rising edge
task automatic model_update();
    int b;
    int p;
    b = btb_slot(commit_pc_i);
    p = int'(commit_pht_index_i);
    if (commit_is_br_i) begin
        if (!commit_btb_hit_i) begin
            m_valid[b]  = 1'b1;                 // Allocate on miss
            m_tag[b]    = commit_pc_i >> (BTB_IW + 2);
            m_target[b] = commit_target_i;
            m_bias[b]   = commit_taken_i;
        end else if (commit_taken_i == commit_bias_i) begin
            m_cnt[p] = (m_cnt[p] == 3) ? 3 : m_cnt[p] + 1;
        end else begin
            m_cnt[p] = (m_cnt[p] == 0) ? 0 : m_cnt[p] - 1;
        end
        m_ghr = (m_ghr * 2 + int'(commit_taken_i)) % PHT_DEPTH;
    end
    m_pc = e_next_pc;
endtask

`endif

//--- tb/branch_unit_tb.sv
// Testbench for the branch prediction front end, checks directed and random traffic against a model
`timescale 1ns/1ps
`default_nettype none

module branch_unit_tb;

    localparam int                BTB_IW      = 4;
    localparam int                PHT_IW      = 6;
    localparam int                BTB_DEPTH   = 2 ** BTB_IW;
    localparam int                PHT_DEPTH   = 2 ** PHT_IW;
    localparam logic [31:0]       RESET_PC    = 32'h0000_1000;
    localparam logic [PHT_IW-1:0] TRAIN_IDX   = 6'd9;       // Pool entry 1 with empty history
    localparam int                RAND_CYCLES = 4000;

    logic              clk_i;
    logic              arst_n_i;
    logic              fetch_en_i;
    logic              commit_is_br_i;
    logic              commit_taken_i;
    logic [31:0]       commit_pc_i;
    logic [31:0]       commit_target_i;
    logic              commit_pred_i;
    logic              commit_bias_i;
    logic              commit_btb_hit_i;
    logic [PHT_IW-1:0] commit_pht_index_i;
    logic [31:0]       fetch_pc_o;
    logic              pred_taken_o;
    logic              btb_hit_o;
    logic              bias_o;
    logic [PHT_IW-1:0] pht_index_o;
    logic              flush_o;

    int                errors;
    int                checks;
    int                test_errors;                     // Error count at test start
    logic              obs_flush;                       // flush_o seen in the last cycle
    logic [31:0]       pool      [8];                   // Commit PCs, reused often
    logic              rec_valid [8];                   // Fetch metadata seen per pool PC
    logic              rec_pred  [8];
    logic              rec_bias  [8];
    logic              rec_hit   [8];
    logic [PHT_IW-1:0] rec_idx   [8];

    `include "bp_model.svh"

    branch_unit_top #(
        .BTB_INDEX_WIDTH (BTB_IW),
        .PHT_INDEX_WIDTH (PHT_IW),
        .RESET_PC        (RESET_PC)
    ) branch_unit_top_inst (
        .clk_i              (clk_i),
        .arst_n_i           (arst_n_i),
        .fetch_en_i         (fetch_en_i),
        .commit_is_br_i     (commit_is_br_i),
        .commit_taken_i     (commit_taken_i),
        .commit_pc_i        (commit_pc_i),
        .commit_target_i    (commit_target_i),
        .commit_pred_i      (commit_pred_i),
        .commit_bias_i      (commit_bias_i),
        .commit_btb_hit_i   (commit_btb_hit_i),
        .commit_pht_index_i (commit_pht_index_i),
        .fetch_pc_o         (fetch_pc_o),
        .pred_taken_o       (pred_taken_o),
        .btb_hit_o          (btb_hit_o),
        .bias_o             (bias_o),
        .pht_index_o        (pht_index_o),
        .flush_o            (flush_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;                      // 4 ns period
    end

    task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0.1f ns: %s is %h, expected %h", $realtime, what, got, exp);
        end
    endtask

    task automatic end_test(input string name);
        $display("Test %s done, %0d mismatches", name, errors - test_errors);
        test_errors = errors;
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        $display("Errors found");
        $finish;
    endtask

    task automatic drive_idle();
        commit_is_br_i     = 1'b0;
        commit_taken_i     = 1'b0;
        commit_pc_i        = '0;
        commit_target_i    = '0;
        commit_pred_i      = 1'b0;
        commit_bias_i      = 1'b0;
        commit_btb_hit_i   = 1'b0;
        commit_pht_index_i = '0;
    endtask

    task automatic drive_commit(input logic taken, input logic [31:0] pc,
                                input logic [31:0] target, input logic pred,
                                input logic bias, input logic hit,
                                input logic [PHT_IW-1:0] idx);
        commit_is_br_i     = 1'b1;
        commit_taken_i     = taken;
        commit_pc_i        = pc;
        commit_target_i    = target;
        commit_pred_i      = pred;
        commit_bias_i      = bias;
        commit_btb_hit_i   = hit;
        commit_pht_index_i = idx;
    endtask

    // One cycle: compare outputs before the edge, advance the model, redrive after the edge
    task automatic step();
        #1;
        model_predict();
        check_eq("fetch_pc_o", fetch_pc_o, m_pc);
        check_eq("btb_hit_o", 32'(btb_hit_o), 32'(e_hit));
        check_eq("pred_taken_o", 32'(pred_taken_o), 32'(e_pred));
        check_eq("pht_index_o", 32'(pht_index_o), 32'(e_idx));
        check_eq("flush_o", 32'(flush_o), 32'(e_flush));
        if (e_bias_valid) begin
            check_eq("bias_o", 32'(bias_o), 32'(e_bias));
        end
        obs_flush = flush_o;
        for (int k = 0; k < 8; k++) begin
            if (fetch_pc_o == pool[k]) begin            // Pipeline keeps fetch metadata
                rec_valid[k] = 1'b1;
                rec_pred[k]  = pred_taken_o;
                rec_bias[k]  = bias_o;
                rec_hit[k]   = btb_hit_o;
                rec_idx[k]   = pht_index_o;
            end
        end
        model_update();
        @(posedge clk_i);
        #0.5;
    endtask

    task automatic commit_repeat(input logic taken, input logic bias, input int count);
        repeat (count) begin
            drive_commit(taken, pool[1], pool[1], taken, bias, 1'b1, TRAIN_IDX);
            step();
        end
        drive_idle();
    endtask

    // Commit one outcome at the training index until the prediction reaches want
    task automatic train_until(input logic taken, input logic bias, input logic want,
                               input int limit, output int n);
        n = 0;
        while (pred_taken_o !== want && n < limit) begin
            drive_commit(taken, pool[1], pool[1], taken, bias, 1'b1, TRAIN_IDX);
            step();
            n++;
        end
        drive_idle();
        if (pred_taken_o !== want) begin
            abort_on_timeout("the agree counter to flip the prediction");
        end
    endtask

    task automatic wait_for_hit(input int limit);
        int n;
        n = 0;
        while (btb_hit_o !== 1'b1 && n < limit) begin
            step();
            n++;
        end
        if (btb_hit_o !== 1'b1) begin
            abort_on_timeout("a BTB hit after allocation");
        end
    endtask

    task automatic random_cycle();
        int          k;
        int          j;
        logic        taken;
        fetch_en_i = ($urandom % 8) != 0;               // Mostly fetching
        k          = int'($urandom % 8);
        j          = int'($urandom % 8);
        taken      = 1'($urandom % 2);
        if ($urandom % 3 == 0) begin
            if (rec_valid[k]) begin
                drive_commit(taken, pool[k], pool[j], rec_pred[k], rec_bias[k], rec_hit[k],
                             rec_idx[k]);
            end else begin
                drive_commit(taken, pool[k], pool[j], 1'b0, 1'b0, 1'b0, PHT_IW'($urandom));
            end
        end else begin
            drive_idle();
        end
        step();
    endtask

    initial begin
        int unsigned seed_ret;
        int          n;
        logic [31:0] pc_hold;
        seed_ret = $urandom(32'h7a63_2ef4);
        errors      = 0;
        checks      = 0;
        test_errors = 0;
        obs_flush   = 1'b0;
        for (int k = 0; k < 6; k++) begin
            pool[k] = RESET_PC + 32'(k) * 32'h24;
        end
        pool[6] = 32'h0000_2000;                        // Aliases pool 0 in the BTB
        pool[7] = 32'h0000_3004;
        for (int k = 0; k < 8; k++) begin
            rec_valid[k] = 1'b0;
            rec_pred[k]  = 1'b0;
            rec_bias[k]  = 1'b0;
            rec_hit[k]   = 1'b0;
            rec_idx[k]   = '0;
        end
        arst_n_i   = 1'b0;
        fetch_en_i = 1'b0;
        drive_idle();
        model_reset();

        @(posedge clk_i);
        #1;
        check_eq("fetch_pc_o in reset", fetch_pc_o, RESET_PC);
        check_eq("btb_hit_o in reset", 32'(btb_hit_o), 32'd0);
        check_eq("flush_o in reset", 32'(flush_o), 32'd0);
        @(posedge clk_i);
        #0.5;
        arst_n_i   = 1'b1;
        fetch_en_i = 1'b1;
        repeat (8) step();
        check_eq("PC after 8 fetches", fetch_pc_o, RESET_PC + 32'd32);
        end_test("reset_state");

        fetch_en_i = 1'b0;
        pc_hold    = fetch_pc_o;
        repeat (5) step();
        check_eq("PC held in stall", fetch_pc_o, pc_hold);
        fetch_en_i = 1'b1;
        end_test("stall");

        // Taken miss allocates pool 1 and redirects fetch to it
        drive_commit(1'b1, pool[1], pool[1], 1'b0, 1'b0, 1'b0, '0);
        step();
        check_eq("flush on allocating commit", 32'(obs_flush), 32'd1);
        drive_idle();
        wait_for_hit(8);
        check_eq("PC at allocated branch", fetch_pc_o, pool[1]);
        check_eq("allocated bias", 32'(bias_o), 32'd1);
        end_test("btb_alloc");

        fetch_en_i = 1'b0;                              // Keep fetch on pool 1
        train_until(1'b0, 1'b1, 1'b0, 20, n);
        commit_repeat(1'b0, 1'b1, 2);                   // Push past zero
        train_until(1'b0, 1'b0, 1'b1, 20, n);
        check_eq("agree commits out of zero", 32'(n), 32'd2);
        commit_repeat(1'b0, 1'b0, 4);                   // Push past three
        train_until(1'b0, 1'b1, 1'b0, 20, n);
        check_eq("disagree commits out of three", 32'(n), 32'd2);
        end_test("agree_training");

        drive_commit(1'b0, pool[3], pool[5], 1'b1, 1'b1, 1'b1, '0);
        step();
        check_eq("flush on not-taken mispredict", 32'(obs_flush), 32'd1);
        check_eq("redirect to fall-through", fetch_pc_o, pool[3] + 32'd4);
        drive_commit(1'b1, pool[4], pool[5], 1'b0, 1'b0, 1'b0, '0);
        step();
        check_eq("flush on taken mispredict", 32'(obs_flush), 32'd1);
        check_eq("redirect to target", fetch_pc_o, pool[5]);
        drive_idle();
        repeat (2) step();
        end_test("mispredict");

        repeat (RAND_CYCLES) random_cycle();
        drive_idle();
        end_test("random_mix");

        $display("Checks: %0d, mismatches: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule : branch_unit_tb

`default_nettype wire

//--- design/branch_unit_top.sv
// Branch prediction front end top level joining index generation, agree predictor and fetch PC
`timescale 1ns/1ps
`default_nettype none

module branch_unit_top #(
    parameter int          BTB_INDEX_WIDTH = 4,
    parameter int          PHT_INDEX_WIDTH = 6,
    parameter logic [31:0] RESET_PC        = 32'h0000_1000
) (
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    input  logic                       fetch_en_i,
    input  logic                       commit_is_br_i,
    input  logic                       commit_taken_i,
    input  logic [bp_pkg::XLEN-1:0]    commit_pc_i,
    input  logic [bp_pkg::XLEN-1:0]    commit_target_i,
    input  logic                       commit_pred_i,
    input  logic                       commit_bias_i,
    input  logic                       commit_btb_hit_i,
    input  logic [PHT_INDEX_WIDTH-1:0] commit_pht_index_i,
    output logic [bp_pkg::XLEN-1:0]    fetch_pc_o,
    output logic                       pred_taken_o,
    output logic                       btb_hit_o,
    output logic                       bias_o,
    output logic [PHT_INDEX_WIDTH-1:0] pht_index_o,    // Travels with the instruction to commit
    output logic                       flush_o
);

    import bp_pkg::*;

    localparam int TAG_W = XLEN - BTB_INDEX_WIDTH - 2;

    logic [BTB_INDEX_WIDTH-1:0] btb_rd_index;
    logic [BTB_INDEX_WIDTH-1:0] btb_wr_index;
    logic [TAG_W-1:0]           if_tag;
    logic [TAG_W-1:0]           btb_wr_tag;
    logic [XLEN-1:0]            btb_target;
    pc_sel_t                    pc_sel;

    ghr_index #(
        .BTB_INDEX_WIDTH (BTB_INDEX_WIDTH),
        .PHT_INDEX_WIDTH (PHT_INDEX_WIDTH)
    ) ghr_index_inst (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .fetch_pc_i     (fetch_pc_o),
        .commit_is_br_i (commit_is_br_i),
        .commit_taken_i (commit_taken_i),
        .commit_pc_i    (commit_pc_i),
        .btb_rd_index_o (btb_rd_index),
        .if_tag_o       (if_tag),
        .btb_wr_index_o (btb_wr_index),
        .btb_wr_tag_o   (btb_wr_tag),
        .pht_rd_index_o (pht_index_o)
    );

    agree_predictor #(
        .BTB_INDEX_WIDTH (BTB_INDEX_WIDTH),
        .PHT_INDEX_WIDTH (PHT_INDEX_WIDTH)
    ) agree_predictor_inst (
        .clk_i              (clk_i),
        .arst_n_i           (arst_n_i),
        .if_tag_i           (if_tag),
        .btb_rd_index_i     (btb_rd_index),
        .btb_wr_index_i     (btb_wr_index),
        .btb_wr_tag_i       (btb_wr_tag),
        .pht_rd_index_i     (pht_index_o),
        .commit_pht_index_i (commit_pht_index_i),
        .commit_target_i    (commit_target_i),
        .commit_is_br_i     (commit_is_br_i),
        .commit_taken_i     (commit_taken_i),
        .commit_pred_i      (commit_pred_i),
        .commit_bias_i      (commit_bias_i),
        .commit_btb_hit_i   (commit_btb_hit_i),
        .btb_hit_o          (btb_hit_o),
        .pred_taken_o       (pred_taken_o),
        .bias_o             (bias_o),
        .btb_target_o       (btb_target),
        .pc_sel_o           (pc_sel),
        .flush_o            (flush_o)
    );

    fetch_pc #(
        .RESET_PC (RESET_PC)
    ) fetch_pc_inst (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .fetch_en_i      (fetch_en_i),
        .pc_sel_i        (pc_sel),
        .flush_i         (flush_o),
        .btb_target_i    (btb_target),
        .commit_pc_i     (commit_pc_i),
        .commit_target_i (commit_target_i),
        .pc_o            (fetch_pc_o)
    );

endmodule : branch_unit_top

`default_nettype wire

//--- design/fetch_pc.sv
// Fetch PC register with four-way next-PC mux, stall hold and flush redirect
`timescale 1ns/1ps
`default_nettype none

module fetch_pc #(
    parameter logic [31:0] RESET_PC = 32'h0000_1000
) (
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    input  logic                    fetch_en_i,       // Low stalls fetch
    input  bp_pkg::pc_sel_t         pc_sel_i,
    input  logic                    flush_i,          // Redirect wins over stall
    input  logic [bp_pkg::XLEN-1:0] btb_target_i,
    input  logic [bp_pkg::XLEN-1:0] commit_pc_i,
    input  logic [bp_pkg::XLEN-1:0] commit_target_i,
    output logic [bp_pkg::XLEN-1:0] pc_o
);

    import bp_pkg::*;

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] commit_plus4;
    logic [XLEN-1:0] pc_next;

    assign pc_plus4     = pc_q + XLEN'(4);
    assign commit_plus4 = commit_pc_i + XLEN'(4);   // Fall-through of mispredicted taken

    always_comb begin
        unique case (pc_sel_i)
            PC_PLUS4:      pc_next = pc_plus4;
            COMMIT_PLUS4:  pc_next = commit_plus4;
            BTB_TARGET:    pc_next = btb_target_i;
            COMMIT_TARGET: pc_next = commit_target_i;
            default:       pc_next = pc_plus4;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= RESET_PC;
        end else if (flush_i || fetch_en_i) begin
            pc_q <= pc_next;                        // Hold while stalled
        end
    end

    assign pc_o = pc_q;

endmodule : fetch_pc

`default_nettype wire

//--- design/ghr_index.sv
// Global history register and BTB/PHT index and tag generation for fetch and commit PCs
`timescale 1ns/1ps
`default_nettype none

module ghr_index #(
    parameter int BTB_INDEX_WIDTH = 4,
    parameter int PHT_INDEX_WIDTH = 6
) (
    input  logic                                    clk_i,
    input  logic                                    arst_n_i,
    input  logic [bp_pkg::XLEN-1:0]                 fetch_pc_i,
    input  logic                                    commit_is_br_i,
    input  logic                                    commit_taken_i,
    input  logic [bp_pkg::XLEN-1:0]                 commit_pc_i,
    output logic [BTB_INDEX_WIDTH-1:0]              btb_rd_index_o,
    output logic [bp_pkg::XLEN-BTB_INDEX_WIDTH-3:0] if_tag_o,
    output logic [BTB_INDEX_WIDTH-1:0]              btb_wr_index_o,
    output logic [bp_pkg::XLEN-BTB_INDEX_WIDTH-3:0] btb_wr_tag_o,
    output logic [PHT_INDEX_WIDTH-1:0]              pht_rd_index_o
);

    import bp_pkg::*;

    logic [PHT_INDEX_WIDTH-1:0] ghr_q;          // Newest outcome in bit 0

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ghr_q <= '0;
        end else if (commit_is_br_i) begin
            ghr_q <= {ghr_q[PHT_INDEX_WIDTH-2:0], commit_taken_i};
        end
    end

    // Word-aligned PCs, so bits [1:0] never enter an index
    assign btb_rd_index_o = fetch_pc_i[BTB_INDEX_WIDTH+1:2];
    assign if_tag_o       = fetch_pc_i[XLEN-1:BTB_INDEX_WIDTH+2];
    assign btb_wr_index_o = commit_pc_i[BTB_INDEX_WIDTH+1:2];
    assign btb_wr_tag_o   = commit_pc_i[XLEN-1:BTB_INDEX_WIDTH+2];
    assign pht_rd_index_o = fetch_pc_i[PHT_INDEX_WIDTH+1:2] ^ ghr_q;   // Gshare hash

    // Commit stage only reports a direction for conditional branches
    a_taken_needs_branch: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        commit_taken_i |-> commit_is_br_i
    );

endmodule : ghr_index

`default_nettype wire

//--- agree_predictor/agree_predictor.sv
// Agree predictor holding the BTB and PHT, producing the fetch prediction, next-PC select and flush
`timescale 1ns/1ps
`default_nettype none

module agree_predictor #(
    parameter int BTB_INDEX_WIDTH = 4,
    parameter int PHT_INDEX_WIDTH = 6
) (
    input  logic                                       clk_i,
    input  logic                                       arst_n_i,
    input  logic [bp_pkg::XLEN-BTB_INDEX_WIDTH-3:0]    if_tag_i,           // Fetch PC tag
    input  logic [BTB_INDEX_WIDTH-1:0]                 btb_rd_index_i,
    input  logic [BTB_INDEX_WIDTH-1:0]                 btb_wr_index_i,
    input  logic [bp_pkg::XLEN-BTB_INDEX_WIDTH-3:0]    btb_wr_tag_i,
    input  logic [PHT_INDEX_WIDTH-1:0]                 pht_rd_index_i,
    input  logic [PHT_INDEX_WIDTH-1:0]                 commit_pht_index_i, // Index used at fetch
    input  logic [bp_pkg::XLEN-1:0]                    commit_target_i,
    input  logic                                       commit_is_br_i,
    input  logic                                       commit_taken_i,
    input  logic                                       commit_pred_i,      // Fetch-time prediction
    input  logic                                       commit_bias_i,
    input  logic                                       commit_btb_hit_i,
    output logic                                       btb_hit_o,
    output logic                                       pred_taken_o,
    output logic                                       bias_o,
    output logic [bp_pkg::XLEN-1:0]                    btb_target_o,
    output bp_pkg::pc_sel_t                            pc_sel_o,
    output logic                                       flush_o
);

    import bp_pkg::*;

    localparam int TAG_W = XLEN - BTB_INDEX_WIDTH - 2;

    logic             btb_wren;                 // Allocate on committed miss
    logic             pht_update_en;            // Train on committed hit
    logic             btb_valid;
    logic [TAG_W-1:0] btb_rd_tag;
    logic             pht_agree;                // Counter says follow bias
    logic             mispredict;

    assign btb_wren      = commit_is_br_i & ~commit_btb_hit_i;
    assign pht_update_en = commit_is_br_i & commit_btb_hit_i;

    agree_btb #(
        .INDEX_WIDTH (BTB_INDEX_WIDTH)
    ) agree_btb_inst (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .rd_index_i  (btb_rd_index_i),
        .wr_index_i  (btb_wr_index_i),
        .wren_i      (btb_wren),
        .wr_tag_i    (btb_wr_tag_i),
        .wr_target_i (commit_target_i),
        .br_taken_i  (commit_taken_i),
        .valid_o     (btb_valid),
        .rd_tag_o    (btb_rd_tag),
        .rd_target_o (btb_target_o),
        .bias_o      (bias_o)
    );

    agree_pht #(
        .INDEX_WIDTH (PHT_INDEX_WIDTH)
    ) agree_pht_inst (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .update_en_i    (pht_update_en),
        .update_index_i (commit_pht_index_i),
        .agree_i        (commit_taken_i ~^ commit_bias_i),  // Outcome matched bias
        .rd_index_i     (pht_rd_index_i),
        .agree_o        (pht_agree)
    );

    assign btb_hit_o    = btb_valid && (btb_rd_tag == if_tag_i);
    assign pred_taken_o = btb_hit_o & (pht_agree ~^ bias_o);    // Disagree inverts the bias
    assign mispredict   = commit_is_br_i & (commit_pred_i ^ commit_taken_i);

    // Recovery from commit overrides the fetch-side prediction
    always_comb begin
        flush_o = mispredict;
        if (mispredict) begin
            pc_sel_o = commit_taken_i ? COMMIT_TARGET : COMMIT_PLUS4;
        end else begin
            pc_sel_o = pred_taken_o ? BTB_TARGET : PC_PLUS4;
        end
    end

    // A taken prediction at fetch only comes from a BTB hit
    a_pred_needs_hit: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        (commit_is_br_i && commit_pred_i) |-> commit_btb_hit_i
    );

endmodule : agree_predictor

`default_nettype wire

//--- agree_predictor/agree_pht.sv
// Pattern history table of 2-bit saturating agree counters, read at fetch and trained at commit
`timescale 1ns/1ps
`default_nettype none

module agree_pht #(
    parameter int INDEX_WIDTH = 6
) (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   update_en_i,     // Train on committed BTB hit
    input  logic [INDEX_WIDTH-1:0] update_index_i,  // Index used at fetch time
    input  logic                   agree_i,         // Outcome matched bias
    input  logic [INDEX_WIDTH-1:0] rd_index_i,      // Fetch lookup index
    output logic                   agree_o          // Counter MSB
);

    import bp_pkg::*;

    localparam int DEPTH = 2 ** INDEX_WIDTH;

    logic [1:0] cnt_q [DEPTH];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                cnt_q[i] <= CNT_RESET;              // All weakly agree
            end
        end else if (update_en_i) begin
            if (agree_i && cnt_q[update_index_i] != 2'b11) begin
                cnt_q[update_index_i] <= cnt_q[update_index_i] + 2'd1;  // Toward strong agree
            end else if (!agree_i && cnt_q[update_index_i] != 2'b00) begin
                cnt_q[update_index_i] <= cnt_q[update_index_i] - 2'd1;  // Toward strong disagree
            end
        end
    end

    assign agree_o = cnt_q[rd_index_i][1];

    // An X index on a write would corrupt an unknown counter
    a_update_index_known: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        update_en_i |-> !$isunknown(update_index_i)
    );

endmodule : agree_pht

`default_nettype wire

//--- agree_predictor/agree_btb.sv
// Direct-mapped branch target buffer, read combinationally at fetch and written at commit on a miss
`timescale 1ns/1ps
`default_nettype none

module agree_btb #(
    parameter int INDEX_WIDTH = 4
) (
    input  logic                                     clk_i,
    input  logic                                     arst_n_i,
    input  logic [INDEX_WIDTH-1:0]                   rd_index_i,   // Fetch lookup index
    input  logic [INDEX_WIDTH-1:0]                   wr_index_i,   // Commit allocate index
    input  logic                                     wren_i,       // Allocate entry
    input  logic [bp_pkg::XLEN-INDEX_WIDTH-3:0]      wr_tag_i,     // Tag of committed PC
    input  logic [bp_pkg::XLEN-1:0]                  wr_target_i,  // Resolved target
    input  logic                                     br_taken_i,   // Outcome becomes the bias
    output logic                                     valid_o,
    output logic [bp_pkg::XLEN-INDEX_WIDTH-3:0]      rd_tag_o,
    output logic [bp_pkg::XLEN-1:0]                  rd_target_o,
    output logic                                     bias_o
);

    import bp_pkg::*;

    localparam int DEPTH = 2 ** INDEX_WIDTH;
    localparam int TAG_W = XLEN - INDEX_WIDTH - 2;

    logic [TAG_W-1:0] tag_q    [DEPTH];             // Tag storage
    logic [XLEN-1:0]  target_q [DEPTH];             // Target storage
    logic [DEPTH-1:0] bias_q;                       // Direction at allocation
    logic [DEPTH-1:0] valid_q;                      // Entry holds a branch

    // Entry valid bits, set on allocation
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
        end else if (wren_i) begin
            valid_q[wr_index_i] <= 1'b1;            // Allocation marks entry live
        end
    end

    always_ff @(posedge clk_i) begin
        if (wren_i) begin
            tag_q[wr_index_i]    <= wr_tag_i;
            target_q[wr_index_i] <= wr_target_i;
            bias_q[wr_index_i]   <= br_taken_i;     // Bias fixed until reallocated
        end
    end

    assign valid_o     = valid_q[rd_index_i];       // Asynchronous read port
    assign rd_tag_o    = tag_q[rd_index_i];
    assign rd_target_o = target_q[rd_index_i];
    assign bias_o      = bias_q[rd_index_i];

endmodule : agree_btb

`default_nettype wire

//--- common/bp_pkg.sv
// Shared widths, next-PC select codes and counter reset value for the branch predictor front end
`default_nettype none

package bp_pkg;

    localparam int XLEN = 32;                   // Instruction address width

    // Next-PC source for the fetch PC mux
    typedef enum logic [1:0] {
        PC_PLUS4      = 2'b00,                  // Sequential fetch
        COMMIT_PLUS4  = 2'b01,                  // Recover to fall-through of committed branch
        BTB_TARGET    = 2'b10,                  // Follow predicted-taken target
        COMMIT_TARGET = 2'b11                   // Recover to resolved branch target
    } pc_sel_t;

    localparam logic [1:0] CNT_RESET = 2'b10;   // Weakly agree

endpackage : bp_pkg

`default_nettype wire
